// File: Makefile
VERILATOR  ?= verilator
TOP        := tb_shuffle_top
FILELIST   := tb.f
OBJ_DIR    := obj_dir
LOG        := sim.log
PASS_MSG   := Simulation completed successfully
LINT_FLAGS := --lint-only -Wall --timing
SIM_FLAGS  := --binary --timing -Wno-fatal -j 0

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || { echo "pass message not found in $(LOG)"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: design/cluster_fork.sv
// Fans the shuffled beat out to every cluster, each with its own valid/ready handshake
`timescale 1ns/1ps

`include "shuffle_config.svh"

module cluster_fork (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  input  shuffle_pkg::wide_beat_t     beat_i,
  input  logic                        valid_i,
  output logic                        ready_o,
  output shuffle_pkg::wide_beat_t     beat_o,
  output logic [`SHF_NR_CLUSTERS-1:0] valid_o,
  input  logic [`SHF_NR_CLUSTERS-1:0] ready_i
);

  // Clusters that already took the current beat
  logic [`SHF_NR_CLUSTERS-1:0] sent_q;
  logic [`SHF_NR_CLUSTERS-1:0] taken;

  assign beat_o  = beat_i;
  assign valid_o = {`SHF_NR_CLUSTERS{valid_i}} & ~sent_q;

  // Taken before, or taking it in this cycle
  assign taken   = sent_q | ready_i;
  assign ready_o = &taken;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      sent_q <= '0;
    end else if (valid_i) begin
      if (ready_o) begin
        // Last cluster took it, start fresh for the next beat
        sent_q <= '0;
      end else begin
        sent_q <= sent_q | (valid_o & ready_i);
      end
    end
  end

endmodule

// File: design/req_tracker.sv
// Circular table of accepted read bursts that hands each shuffle stage the enable of its burst
`timescale 1ns/1ps

`include "shuffle_config.svh"

module req_tracker (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  shuffle_pkg::rd_req_t   req_i,
  input  logic                   req_valid_i,
  output logic                   req_ready_o,
  input  shuffle_pkg::stage_en_t stage_done_i,
  output shuffle_pkg::stage_en_t stage_en_o
);
  import shuffle_pkg::*;

  sew_e                           sew_q [`SHF_NUM_TRACKERS];
  trk_ptr_t                       accept_pnt_q;
  trk_ptr_t [`SHF_NUM_STAGES-1:0] issue_pnt_q;
  trk_cnt_t                       cnt_q;
  trk_cnt_t                       cnt_d;
  logic                           req_fire;
  logic                           retire;

  // Advance a table pointer with wrap-around
  function automatic trk_ptr_t next_ptr(trk_ptr_t ptr);
    trk_ptr_t nxt;
    if (ptr == trk_ptr_t'(`SHF_NUM_TRACKERS - 1)) begin
      nxt = '0;
    end else begin
      nxt = ptr + 1'b1;
    end
    return nxt;
  endfunction

  //////////////////////////////////////////////////
  // Accept and retire
  //////////////////////////////////////////////////

  // Full exactly while every entry holds an outstanding burst
  assign req_ready_o = (cnt_q != trk_cnt_t'(`SHF_NUM_TRACKERS));
  assign req_fire    = req_valid_i && req_ready_o;

  // A burst is done once its last beat has passed the final stage
  assign retire = stage_done_i[`SHF_NUM_STAGES-1];

  always_comb begin
    cnt_d = cnt_q;
    if (req_fire && !retire) begin
      cnt_d = cnt_q + 1'b1;
    end else if (!req_fire && retire) begin
      cnt_d = cnt_q - 1'b1;
    end
  end

  // Element width table
  always_ff @(posedge clk_i) begin
    if (req_fire) begin
      sew_q[accept_pnt_q] <= req_i.sew;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      accept_pnt_q <= '0;
      cnt_q        <= '0;
    end else begin
      cnt_q <= cnt_d;
      if (req_fire) begin
        accept_pnt_q <= next_ptr(accept_pnt_q);
      end
    end
  end

  //////////////////////////////////////////////////
  // Per-stage issue pointers
  //////////////////////////////////////////////////

  // Each stage moves to the next burst after its own last beat
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      issue_pnt_q <= '0;
    end else begin
      for (int s = 0; s < `SHF_NUM_STAGES; s++) begin
        if (stage_done_i[s]) begin
          issue_pnt_q[s] <= next_ptr(issue_pnt_q[s]);
        end
      end
    end
  end

  // Stages at or above the element width index are active
  // SEW8 uses every stage, SEW32 passes straight through
  for (genvar s = 0; s < `SHF_NUM_STAGES; s++) begin : g_stage_en
    assign stage_en_o[s] = (s >= int'(sew_q[issue_pnt_q[s]]));
  end

endmodule

// File: design/shuffle_config.svh
// Sizing macros for the read shuffle network, included by the package, the RTL and the testbench
`ifndef SHUFFLE_CONFIG_SVH
`define SHUFFLE_CONFIG_SVH

//////////////////////////////////////////////////
// Datapath geometry
//////////////////////////////////////////////////

// Lanes inside one cluster
`define SHF_NR_LANES 2

// Clusters fed by the shuffle network
`define SHF_NR_CLUSTERS 4

// Data bits delivered to one cluster per beat (32 bits per lane)
`define SHF_CLUSTER_DW 64

// Width of the full response beat across all clusters
`define SHF_TOTAL_DW (`SHF_NR_CLUSTERS * `SHF_CLUSTER_DW)

//////////////////////////////////////////////////
// Network and tracker depth
//////////////////////////////////////////////////

// One stage per doubling from byte elements up to a full lane group
`define SHF_NUM_STAGES $clog2(`SHF_CLUSTER_DW / (8 * `SHF_NR_LANES))

// Read bursts that may be outstanding at once
`define SHF_NUM_TRACKERS 8

`endif

// File: design/shuffle_pkg.sv
// Shared types of the read shuffle network, compiled before every module that uses them
package shuffle_pkg;

`include "shuffle_config.svh"

  //////////////////////////////////////////////////
  // Request side
  //////////////////////////////////////////////////

  // Element width of a read burst
  typedef enum logic [1:0] {
    SEW8  = 2'd0,
    SEW16 = 2'd1,
    SEW32 = 2'd2
  } sew_e;

  // Read request, len counts beats minus one
  typedef struct packed {
    sew_e       sew;
    logic [7:0] len;
  } rd_req_t;

  // Tracker table pointer and occupancy count
  typedef logic [$clog2(`SHF_NUM_TRACKERS)-1:0] trk_ptr_t;
  typedef logic [$clog2(`SHF_NUM_TRACKERS):0]   trk_cnt_t;

  //////////////////////////////////////////////////
  // Response side
  //////////////////////////////////////////////////

  // Slice of a response beat owned by one cluster
  typedef struct packed {
    logic [`SHF_CLUSTER_DW-1:0] data;
    logic                       last;
  } cluster_beat_t;

  // Full response beat, cluster 0 in the lowest slot
  typedef cluster_beat_t [`SHF_NR_CLUSTERS-1:0] wide_beat_t;

  // Data of all clusters laid end to end
  typedef logic [`SHF_TOTAL_DW-1:0] flat_data_t;

  // One bit per shuffle stage
  typedef logic [`SHF_NUM_STAGES-1:0] stage_en_t;

endpackage

// File: design/shuffle_stage.sv
// One registered permutation stage of the read shuffle chain, block size set by its index
`timescale 1ns/1ps

`include "shuffle_config.svh"

module shuffle_stage #(
  parameter int unsigned STAGE = 0
) (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  shuffle_pkg::wide_beat_t beat_i,
  input  logic                    valid_i,
  output logic                    ready_o,
  input  logic                    en_i,
  output shuffle_pkg::wide_beat_t beat_o,
  output logic                    valid_o,
  input  logic                    ready_i,
  output logic                    done_o
);
  import shuffle_pkg::*;

  // Blocks double in size from one stage to the next
  localparam int unsigned BLOCK_W = (8 * `SHF_NR_LANES) << STAGE;
  localparam int unsigned ITERS   = `SHF_TOTAL_DW / BLOCK_W / 2;

  flat_data_t data_in;
  flat_data_t data_shf;
  wide_beat_t beat_shf;
  wide_beat_t beat_q;
  logic       valid_q;
  logic       accept;

  //////////////////////////////////////////////////
  // Permutation
  //////////////////////////////////////////////////

  always_comb begin
    for (int c = 0; c < `SHF_NR_CLUSTERS; c++) begin
      data_in[c*`SHF_CLUSTER_DW +: `SHF_CLUSTER_DW] = beat_i[c].data;
    end
  end

  // Interleave the lower and upper half block by block
  always_comb begin
    data_shf = data_in;
    if (en_i) begin
      for (int i = 0; i < ITERS; i++) begin
        for (int j = 0; j < 2; j++) begin
          data_shf[(2*i+j)*BLOCK_W +: BLOCK_W] = data_in[(j*ITERS+i)*BLOCK_W +: BLOCK_W];
        end
      end
    end
  end

  // Last flags stay with their slot
  always_comb begin
    beat_shf = beat_i;
    for (int c = 0; c < `SHF_NR_CLUSTERS; c++) begin
      beat_shf[c].data = data_shf[c*`SHF_CLUSTER_DW +: `SHF_CLUSTER_DW];
    end
  end

  //////////////////////////////////////////////////
  // Pipeline slot
  //////////////////////////////////////////////////

  assign ready_o = !valid_q || ready_i;
  assign accept  = valid_i && ready_o;
  assign done_o  = accept && beat_i[0].last;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= 1'b0;
    end else if (accept) begin
      valid_q <= 1'b1;
    end else if (ready_i) begin
      valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      beat_q <= beat_shf;
    end
  end

  assign beat_o  = beat_q;
  assign valid_o = valid_q;

endmodule

// File: design/shuffle_top.sv
// Top of the read shuffle network: tracker, generated shuffle stages and cluster fork
`timescale 1ns/1ps

`include "shuffle_config.svh"

module shuffle_top (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  // Read requests
  input  shuffle_pkg::rd_req_t        req_i,
  input  logic                        req_valid_i,
  output logic                        req_ready_o,
  // Wide response beats from memory
  input  shuffle_pkg::wide_beat_t     beat_i,
  input  logic                        beat_valid_i,
  output logic                        beat_ready_o,
  // Shuffled beats, one handshake per cluster
  output shuffle_pkg::wide_beat_t     beat_o,
  output logic [`SHF_NR_CLUSTERS-1:0] beat_valid_o,
  input  logic [`SHF_NR_CLUSTERS-1:0] beat_ready_i
);
  import shuffle_pkg::*;

  // Slot s is the input of stage s, the last slot feeds the fork
  wide_beat_t [`SHF_NUM_STAGES:0] pipe_beat;
  logic       [`SHF_NUM_STAGES:0] pipe_valid;
  logic       [`SHF_NUM_STAGES:0] pipe_ready;
  stage_en_t                      stage_en;
  stage_en_t                      stage_done;

  assign pipe_beat[0]  = beat_i;
  assign pipe_valid[0] = beat_valid_i;
  assign beat_ready_o  = pipe_ready[0];

  req_tracker i_req_tracker (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .req_i        (req_i),
    .req_valid_i  (req_valid_i),
    .req_ready_o  (req_ready_o),
    .stage_done_i (stage_done),
    .stage_en_o   (stage_en)
  );

  //////////////////////////////////////////////////
  // Shuffle chain
  //////////////////////////////////////////////////

  for (genvar s = 0; s < `SHF_NUM_STAGES; s++) begin : g_stage
    shuffle_stage #(
      .STAGE (s)
    ) i_shuffle_stage (
      .clk_i   (clk_i),
      .rst_ni  (rst_ni),
      .beat_i  (pipe_beat[s]),
      .valid_i (pipe_valid[s]),
      .ready_o (pipe_ready[s]),
      .en_i    (stage_en[s]),
      .beat_o  (pipe_beat[s+1]),
      .valid_o (pipe_valid[s+1]),
      .ready_i (pipe_ready[s+1]),
      .done_o  (stage_done[s])
    );
  end

  cluster_fork i_cluster_fork (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .beat_i  (pipe_beat[`SHF_NUM_STAGES]),
    .valid_i (pipe_valid[`SHF_NUM_STAGES]),
    .ready_o (pipe_ready[`SHF_NUM_STAGES]),
    .beat_o  (beat_o),
    .valid_o (beat_valid_o),
    .ready_i (beat_ready_i)
  );

endmodule

// File: tb.f
+incdir+design
+incdir+test
design/shuffle_pkg.sv
design/req_tracker.sv
design/shuffle_stage.sv
design/cluster_fork.sv
design/shuffle_top.sv
test/tb_shuffle_top.sv

// File: test/tb_shuffle_tests.svh
// Directed tests of the read shuffle network that the testbench top module includes
`ifndef TB_SHUFFLE_TESTS_SVH
`define TB_SHUFFLE_TESTS_SVH

  // All outputs idle and both channels open
  task automatic test_reset_state();
    test_name = "reset_state";
    @(negedge clk_i);
    check_val("beat_valid_o", '0, 128'(beat_valid_o));
    check_val("req_ready_o", 128'(1), 128'(req_ready_o));
    check_val("beat_ready_o", 128'(1), 128'(beat_ready_o));
  endtask

  // Four beats through both stages with last only on beat 4
  task automatic test_sew8_burst();
    test_name = "sew8_burst";
    send_req(SEW8, 3);
    send_burst(SEW8, 3);
    end_beats();
    wait_drained();
  endtask

  task automatic test_sew16_sew32();
    test_name = "sew16_sew32";
    send_req(SEW16, 1);
    send_req(SEW32, 1);
    send_burst(SEW16, 1);
    send_burst(SEW32, 1);
    end_beats();
    wait_drained();
  endtask

  ////////////////////////////////////////////////
  // Tracker and flow control
  ////////////////////////////////////////////////

  // Fill every entry and free one by finishing the oldest burst
  task automatic test_tracker_full();
    int t;
    test_name = "tracker_full";
    for (int k = 0; k < `SHF_NUM_TRACKERS; k++) begin
      send_req(sew_e'(k % 3), 0);
    end
    check_val("req_ready_o when full", '0, 128'(req_ready_o));
    send_burst(sew_e'(0), 0);
    end_beats();
    t = 0;
    while (!req_ready_o && t < TIMEOUT) begin
      t++;
      @(negedge clk_i);
    end
    if (!req_ready_o) begin
      stop_on_timeout("req_ready_o to rise again");
    end
    for (int k = 1; k < `SHF_NUM_TRACKERS; k++) begin
      send_burst(sew_e'(k % 3), 0);
    end
    end_beats();
    wait_drained();
  endtask

  task automatic test_back_pressure();
    test_name = "back_pressure";
    bp_mode   = 1'b1;
    send_req(SEW8, 5);
    send_req(SEW16, 6);
    send_burst(SEW8, 5);
    send_burst(SEW16, 6);
    end_beats();
    wait_drained();
    // Nothing may still be offered once every beat arrived
    check_val("beat_valid_o after drain", '0, 128'(beat_valid_o));
    bp_mode = 1'b0;
  endtask

  task automatic test_mixed_widths();
    test_name = "mixed_widths";
    send_req(SEW8, 0);
    send_req(SEW32, 0);
    send_req(SEW16, 0);
    send_burst(SEW8, 0);
    send_burst(SEW32, 0);
    send_burst(SEW16, 0);
    end_beats();
    wait_drained();
  endtask

`endif

// File: test/tb_shuffle_top.sv
// Testbench top for the read shuffle network, runs the directed tests from the included task file
`timescale 1ns/1ps

`include "shuffle_config.svh"

module tb_shuffle_top;
  import shuffle_pkg::*;

  localparam int TIMEOUT = 200;

  logic                        clk_i;
  logic                        rst_ni;
  rd_req_t                     req_i;
  logic                        req_valid_i;
  logic                        req_ready_o;
  wide_beat_t                  beat_i;
  logic                        beat_valid_i;
  logic                        beat_ready_o;
  wide_beat_t                  beat_o;
  logic [`SHF_NR_CLUSTERS-1:0] beat_valid_o;
  logic [`SHF_NR_CLUSTERS-1:0] beat_ready_i;

  // Expected beats in send order, each cluster keeps its own read position
  wide_beat_t  exp_q[$];
  int          rx_cnt [`SHF_NR_CLUSTERS];
  logic [31:0] data_rng = 32'h99e5_fb92;
  logic [31:0] bp_rng;
  logic        bp_mode;
  string       test_name;
  int          n_checks;
  int          n_errors;

  shuffle_top i_shuffle_top (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .req_i        (req_i),
    .req_valid_i  (req_valid_i),
    .req_ready_o  (req_ready_o),
    .beat_i       (beat_i),
    .beat_valid_i (beat_valid_i),
    .beat_ready_o (beat_ready_o),
    .beat_o       (beat_o),
    .beat_valid_o (beat_valid_o),
    .beat_ready_i (beat_ready_i)
  );

  initial begin
    clk_i = 1'b0;
    forever #20 clk_i = ~clk_i;
  end

  function automatic logic [31:0] xorshift32(logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic logic [31:0] rand_word();
    data_rng = xorshift32(data_rng);
    return data_rng;
  endfunction

  task automatic check_val(input string what, input logic [127:0] expected,
                           input logic [127:0] actual);
    n_checks++;
    if (expected !== actual) begin
      n_errors++;
      $display("error %s %s: expected %0h, actual %0h", test_name, what, expected, actual);
    end
  endtask

  task automatic stop_on_timeout(input string what);
    $display("timeout in %s while waiting for %s", test_name, what);
    $display("checks %0d, errors %0d", n_checks, n_errors + 1);
    $display("Simulation failed");
    $finish;
  endtask

  //////////////////////////////////////////////////
  // Reference model
  //////////////////////////////////////////////////

  // Output block o comes from input block (o mod 2) * half + o / 2
  function automatic flat_data_t model_stage(flat_data_t d, int stage);
    flat_data_t r;
    int         blk;
    int         half;
    int         o;
    blk  = 8 * `SHF_NR_LANES * (1 << stage);
    half = `SHF_TOTAL_DW / (2 * blk);
    for (int b = 0; b < `SHF_TOTAL_DW; b++) begin
      o    = b / blk;
      r[b] = d[((o % 2) * half + o / 2) * blk + b % blk];
    end
    return r;
  endfunction

  // Narrower elements go through more stages, last flags never move
  function automatic wide_beat_t model_beat(wide_beat_t in, sew_e width);
    wide_beat_t r;
    flat_data_t d;
    r = in;
    for (int c = 0; c < `SHF_NR_CLUSTERS; c++) begin
      d[c*`SHF_CLUSTER_DW +: `SHF_CLUSTER_DW] = in[c].data;
    end
    for (int s = 0; s < `SHF_NUM_STAGES; s++) begin
      if (int'(width) <= s) begin
        d = model_stage(d, s);
      end
    end
    for (int c = 0; c < `SHF_NR_CLUSTERS; c++) begin
      r[c].data = d[c*`SHF_CLUSTER_DW +: `SHF_CLUSTER_DW];
    end
    return r;
  endfunction

  //////////////////////////////////////////////////
  // Drivers and monitor
  //////////////////////////////////////////////////

  task automatic send_req(input sew_e width, input int len);
    int t;
    @(negedge clk_i);
    req_i.sew   = width;
    req_i.len   = 8'(len);
    req_valid_i = 1'b1;
    t = 0;
    @(posedge clk_i);
    while (!req_ready_o && t < TIMEOUT) begin
      t++;
      @(posedge clk_i);
    end
    if (t >= TIMEOUT) begin
      stop_on_timeout("request ready");
    end
    @(negedge clk_i);
    req_valid_i = 1'b0;
  endtask

  task automatic send_beat(input wide_beat_t b, input sew_e width);
    int t;
    @(negedge clk_i);
    beat_i       = b;
    beat_valid_i = 1'b1;
    exp_q.push_back(model_beat(b, width));
    t = 0;
    @(posedge clk_i);
    while (!beat_ready_o && t < TIMEOUT) begin
      t++;
      @(posedge clk_i);
    end
    if (t >= TIMEOUT) begin
      stop_on_timeout("input beat ready");
    end
  endtask

  // Random data, last set in every cluster slot of the final beat
  task automatic send_burst(input sew_e width, input int len);
    wide_beat_t b;
    for (int k = 0; k <= len; k++) begin
      for (int c = 0; c < `SHF_NR_CLUSTERS; c++) begin
        b[c].data = {rand_word(), rand_word()};
        b[c].last = (k == len);
      end
      send_beat(b, width);
    end
  endtask

  task automatic end_beats();
    @(negedge clk_i);
    beat_valid_i = 1'b0;
  endtask

  function automatic bit all_received();
    bit done;
    done = 1'b1;
    for (int c = 0; c < `SHF_NR_CLUSTERS; c++) begin
      if (rx_cnt[c] != exp_q.size()) begin
        done = 1'b0;
      end
    end
    return done;
  endfunction

  task automatic wait_drained();
    int t;
    t = 0;
    while (!all_received() && t < TIMEOUT) begin
      t++;
      @(negedge clk_i);
    end
    if (!all_received()) begin
      stop_on_timeout("all clusters to receive their beats");
    end
  endtask

  always @(negedge clk_i) begin : ready_driver
    if (bp_mode) begin
      bp_rng       = xorshift32(bp_rng);
      beat_ready_i = bp_rng[`SHF_NR_CLUSTERS-1:0];
    end else begin
      beat_ready_i = '1;
    end
  end

  // Each cluster must see the expected beats in order, once each
  always @(posedge clk_i) begin : rx_monitor
    if (rst_ni) begin
      for (int c = 0; c < `SHF_NR_CLUSTERS; c++) begin
        if (beat_valid_o[c] && beat_ready_i[c]) begin
          if (rx_cnt[c] >= exp_q.size()) begin
            n_errors++;
            $display("cluster %0d received a beat that was never sent", c);
          end else begin
            check_val($sformatf("cluster %0d beat %0d", c, rx_cnt[c]),
                      128'(exp_q[rx_cnt[c]][c]), 128'(beat_o[c]));
          end
          rx_cnt[c]++;
        end
      end
    end
  end

`include "tb_shuffle_tests.svh"

  initial begin
    rst_ni       = 1'b0;
    req_i        = '0;
    req_valid_i  = 1'b0;
    beat_i       = '0;
    beat_valid_i = 1'b0;
    beat_ready_i = '1;
    bp_mode      = 1'b0;
    bp_rng       = xorshift32(32'h99e5_fb92);
    n_checks     = 0;
    n_errors     = 0;
    test_name    = "reset";
    for (int c = 0; c < `SHF_NR_CLUSTERS; c++) begin
      rx_cnt[c] = 0;
    end
    repeat (4) @(posedge clk_i);
    @(negedge clk_i);
    rst_ni = 1'b1;

    test_reset_state();
    test_sew8_burst();
    test_sew16_sew32();
    test_tracker_full();
    test_back_pressure();
    test_mixed_widths();

    $display("checks %0d, errors %0d", n_checks, n_errors);
    if (n_errors == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule
